// ==== hdl/mram_macros.svh ====
`ifndef MRAM_MACROS_SVH
`define MRAM_MACROS_SVH

// User word and byte split
`define MRAM_DATA_WIDTH     32
`define MRAM_BYTES          4
`define MRAM_BYTE_WIDTH     8

// Extended Hamming (13,8) codeword per byte
`define MRAM_CHECK_WIDTH    4
`define MRAM_CODE_WIDTH     13

// Address map: upper bits pick the bank, lower bits the row
`define MRAM_ADDR_WIDTH     9
`define MRAM_ROW_WIDTH      6
`define MRAM_BANKS          8
`define MRAM_BANK_SEL_WIDTH 3

`endif

// ==== hdl/mram_pkg.sv ====
`include "mram_macros.svh"

package mram_pkg;

  // Field view of one byte codeword, overall parity on top
  typedef struct packed {
    logic                           ovr;
    logic [`MRAM_CHECK_WIDTH-1:0]   check;
    logic [`MRAM_BYTE_WIDTH-1:0]    data;
  } secded_fields_t;

  // Same 13 bits, either as fields or as one vector for the parity reduction
  typedef union packed {
    secded_fields_t                 f;
    logic [`MRAM_CODE_WIDTH-1:0]    flat;
  } secded_word_t;

  // One bank row, one codeword per byte lane
  typedef secded_word_t stored_word_t [`MRAM_BYTES];

endpackage

// ==== hdl/secded_encoder.sv ====
`timescale 1ns/1ps

`include "mram_macros.svh"

module secded_encoder (
  input  logic [`MRAM_BYTE_WIDTH-1:0]  data,
  input  logic                         bypass,
  output mram_pkg::secded_word_t       code
);

  logic [`MRAM_CHECK_WIDTH-1:0] chk;

  // Data bits 0..7 live at Hamming positions 3,5,6,7,9,10,11,12
  assign chk[0] = data[0] ^ data[1] ^ data[3] ^ data[4] ^ data[6];
  assign chk[1] = data[0] ^ data[2] ^ data[3] ^ data[5] ^ data[6];
  assign chk[2] = data[1] ^ data[2] ^ data[3] ^ data[7];
  assign chk[3] = data[4] ^ data[5] ^ data[6] ^ data[7];

  always_comb begin
    code.f.data = data;
    if (bypass) begin
      code.f.check = '0;
      code.f.ovr   = 1'b0;
    end else begin
      code.f.check = chk;
      // DED bit covers data and checks
      code.f.ovr   = ^{chk, data};
    end
  end

endmodule

// ==== hdl/secded_decoder.sv ====
`timescale 1ns/1ps

`include "mram_macros.svh"

module secded_decoder (
  input  mram_pkg::secded_word_t       code,
  input  logic                         bypass,
  output logic [`MRAM_BYTE_WIDTH-1:0]  data,
  output logic                         errf,
  output logic                         ue
);

  logic [`MRAM_BYTE_WIDTH-1:0]  d;
  logic [`MRAM_CHECK_WIDTH-1:0] chk;
  logic [`MRAM_CHECK_WIDTH-1:0] syn;
  logic                         ovr_odd;
  logic [`MRAM_BYTE_WIDTH-1:0]  flip;

  assign d = code.f.data;

  assign chk[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
  assign chk[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
  assign chk[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
  assign chk[3] = d[4] ^ d[5] ^ d[6] ^ d[7];

  assign syn     = chk ^ code.f.check;
  assign ovr_odd = ^code.flat;

  // Syndrome gives the Hamming position of a single flipped bit
  always_comb begin
    flip = '0;
    case (syn)
      4'd3:    flip[0] = 1'b1;
      4'd5:    flip[1] = 1'b1;
      4'd6:    flip[2] = 1'b1;
      4'd7:    flip[3] = 1'b1;
      4'd9:    flip[4] = 1'b1;
      4'd10:   flip[5] = 1'b1;
      4'd11:   flip[6] = 1'b1;
      4'd12:   flip[7] = 1'b1;
      default: flip    = '0;
    endcase
  end

  // ===========================================================================
  // Error classification
  // ===========================================================================
  always_comb begin
    data = d;
    errf = 1'b0;
    ue   = 1'b0;
    if (!bypass) begin
      if (ovr_odd) begin
        // Odd weight: one bit flipped, check and parity positions leave data alone
        errf = 1'b1;
        data = d ^ flip;
      end else if (syn != '0) begin
        // Even weight with nonzero syndrome: two bits flipped
        errf = 1'b1;
        ue   = 1'b1;
      end
    end
  end

  always_comb begin
    a_ue_flags: assert (!ue || (errf && !bypass))
      else $error("secded_decoder: ue without errf or during bypass");
  end

endmodule

// ==== hdl/mram_bank.sv ====
`timescale 1ns/1ps

`include "mram_macros.svh"

module mram_bank (
  input  logic                         CLK,
  input  logic                         sel,
  input  logic                         web,
  input  logic [`MRAM_BYTES-1:0]       ben_act,
  input  logic [`MRAM_ROW_WIDTH-1:0]   row,
  input  mram_pkg::stored_word_t       wdata,
  output mram_pkg::stored_word_t       rdata
);

  localparam int ROWS = 1 << `MRAM_ROW_WIDTH;

  mram_pkg::stored_word_t mem [ROWS];

  // Byte-masked write or registered read, one per selected cycle
  always_ff @(posedge CLK) begin
    if (sel) begin
      if (!web) begin
        for (int b = 0; b < `MRAM_BYTES; b++) begin
          if (ben_act[b]) begin
            mem[row][b] <= wdata[b];
          end
        end
      end else begin
        rdata <= mem[row];
      end
    end
  end

endmodule

// ==== hdl/bank_array.sv ====
`timescale 1ns/1ps

`include "mram_macros.svh"

module bank_array (
  input  logic                         CLK,
  input  logic                         RSTB,
  input  logic                         ceb,
  input  logic                         web,
  input  logic [`MRAM_BYTES-1:0]       ben_act,
  input  logic [`MRAM_ADDR_WIDTH-1:0]  addr,
  input  mram_pkg::stored_word_t       wdata,
  output mram_pkg::stored_word_t       rdata
);

  logic [`MRAM_BANK_SEL_WIDTH-1:0] bank_idx;
  logic [`MRAM_BANKS-1:0]          sel;
  logic [`MRAM_BANK_SEL_WIDTH-1:0] rd_bank;
  mram_pkg::stored_word_t          bank_rdata [`MRAM_BANKS];

  assign bank_idx = addr[`MRAM_ADDR_WIDTH-1 -: `MRAM_BANK_SEL_WIDTH];

  // One-hot bank select
  always_comb begin
    sel = '0;
    if (!ceb) begin
      sel[bank_idx] = 1'b1;
    end
  end

  // Remember which bank holds the pending read data
  always_ff @(posedge CLK or negedge RSTB) begin
    if (!RSTB) begin
      rd_bank <= '0;
    end else if (!ceb && web) begin
      rd_bank <= bank_idx;
    end
  end

  // ===========================================================================
  // Banks
  // ===========================================================================
  for (genvar i = 0; i < `MRAM_BANKS; i++) begin : g_bank
    mram_bank u_bank (
      .CLK     (CLK),
      .sel     (sel[i]),
      .web     (web),
      .ben_act (ben_act),
      .row     (addr[`MRAM_ROW_WIDTH-1:0]),
      .wdata   (wdata),
      .rdata   (bank_rdata[i])
    );
  end

  assign rdata = bank_rdata[rd_bank];

  a_sel_onehot: assert property (@(posedge CLK) disable iff (!RSTB) $onehot0(sel))
    else $error("bank_array: more than one bank selected");

endmodule

// ==== hdl/mram_ecc_top.sv ====
`timescale 1ns/1ps

`include "mram_macros.svh"

module mram_ecc_top (
  input  logic                         CLK,
  input  logic                         RSTB,
  input  logic [`MRAM_ADDR_WIDTH-1:0]  a,
  input  logic [`MRAM_DATA_WIDTH-1:0]  din,
  input  logic                         ceb,
  input  logic                         web,
  input  logic [`MRAM_BYTES-1:0]       ben,
  input  logic                         bypass,
  output logic [`MRAM_DATA_WIDTH-1:0]  dout,
  output logic [`MRAM_BYTES-1:0]       errf,
  output logic [`MRAM_BYTES-1:0]       ue
);

  logic [`MRAM_ADDR_WIDTH-1:0] cmd_addr;
  logic                        cmd_en;
  logic                        cmd_web;
  logic                        cmd_bypass;
  logic [`MRAM_BYTES-1:0]      cmd_ben;
  mram_pkg::stored_word_t      enc_code;
  mram_pkg::stored_word_t      cmd_code;

  logic                        rd_go;
  logic [`MRAM_BYTES-1:0]      rd_ben;
  logic                        rd_bypass;
  mram_pkg::stored_word_t      arr_rdata;
  mram_pkg::stored_word_t      dec_in;

  // ===========================================================================
  // Stage 1: command latch and encoding
  // ===========================================================================
  // Chip enable kept active high so a cleared register selects nothing
  always_ff @(posedge CLK or negedge RSTB) begin
    if (!RSTB) begin
      cmd_addr   <= '0;
      cmd_en     <= 1'b0;
      cmd_web    <= 1'b0;
      cmd_bypass <= 1'b0;
      cmd_ben    <= '0;
    end else begin
      cmd_addr   <= a;
      cmd_en     <= ~ceb;
      cmd_web    <= web;
      cmd_bypass <= bypass;
      cmd_ben    <= ~ben;
    end
  end

  for (genvar b = 0; b < `MRAM_BYTES; b++) begin : g_enc
    secded_encoder u_enc (
      .data   (din[b*`MRAM_BYTE_WIDTH +: `MRAM_BYTE_WIDTH]),
      .bypass (bypass),
      .code   (enc_code[b])
    );
  end

  always_ff @(posedge CLK) begin
    cmd_code <= enc_code;
  end

  // ===========================================================================
  // Array and read-side control
  // ===========================================================================
  bank_array u_array (
    .CLK     (CLK),
    .RSTB    (RSTB),
    .ceb     (~cmd_en),
    .web     (cmd_web),
    .ben_act (cmd_ben),
    .addr    (cmd_addr),
    .wdata   (cmd_code),
    .rdata   (arr_rdata)
  );

  assign rd_go = cmd_en && cmd_web;

  // Byte mask and bypass follow the read into the decode stage
  always_ff @(posedge CLK or negedge RSTB) begin
    if (!RSTB) begin
      rd_ben    <= '0;
      rd_bypass <= 1'b0;
    end else if (rd_go) begin
      rd_ben    <= cmd_ben;
      rd_bypass <= cmd_bypass;
    end
  end

  // ===========================================================================
  // Decode
  // ===========================================================================
  for (genvar b = 0; b < `MRAM_BYTES; b++) begin : g_dec
    // Masked byte decodes as an all-zero codeword
    assign dec_in[b] = rd_ben[b] ? arr_rdata[b] : '0;

    secded_decoder u_dec (
      .code   (dec_in[b]),
      .bypass (rd_bypass),
      .data   (dout[b*`MRAM_BYTE_WIDTH +: `MRAM_BYTE_WIDTH]),
      .errf   (errf[b]),
      .ue     (ue[b])
    );
  end

  a_dout_known: assert property (@(posedge CLK) disable iff (!RSTB)
    rd_go |=> !$isunknown(dout))
    else $error("mram_ecc_top: unknown bits on dout after read");

endmodule

// ==== sim/tb_mram_ecc.sv ====
`timescale 1ns/1ps

`include "mram_macros.svh"

module tb_mram_ecc;

  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_RD   = 2'd2;
  localparam int MAX_ROWS        = 80;
  localparam int RESET_TIMEOUT   = 20;
  localparam int DRAIN_TIMEOUT   = 10;

  typedef struct packed {
    logic [1:0]                   op;
    logic [`MRAM_ADDR_WIDTH-1:0]  addr;
    logic [`MRAM_DATA_WIDTH-1:0]  data;
    logic [`MRAM_BYTES-1:0]       ben;
    logic                         bypass;
  } row_t;

  logic                         CLK;
  logic                         RSTB;
  logic [`MRAM_ADDR_WIDTH-1:0]  a;
  logic [`MRAM_DATA_WIDTH-1:0]  din;
  logic                         ceb;
  logic                         web;
  logic [`MRAM_BYTES-1:0]       ben;
  logic                         bypass;
  logic [`MRAM_DATA_WIDTH-1:0]  dout;
  logic [`MRAM_BYTES-1:0]       errf;
  logic [`MRAM_BYTES-1:0]       ue;

  row_t                         rows [MAX_ROWS];
  int                           n_rows;
  logic [`MRAM_DATA_WIDTH-1:0]  exp_dout [MAX_ROWS];
  logic [`MRAM_BYTES-1:0]       exp_errf [MAX_ROWS];
  logic [`MRAM_BYTES-1:0]       exp_ue   [MAX_ROWS];
  logic [`MRAM_CODE_WIDTH-1:0]  shadow [1 << `MRAM_ADDR_WIDTH][`MRAM_BYTES];

  // Last completed read, held by the DUT until the next one
  logic [`MRAM_DATA_WIDTH-1:0]  held_dout;
  logic [`MRAM_BYTES-1:0]       held_errf;
  logic [`MRAM_BYTES-1:0]       held_ue;

  int                           mismatches;
  int                           other_errors;
  int                           checks;
  int                           next_check;
  integer                       seed;

  mram_ecc_top u_dut (
    .CLK    (CLK),
    .RSTB   (RSTB),
    .a      (a),
    .din    (din),
    .ceb    (ceb),
    .web    (web),
    .ben    (ben),
    .bypass (bypass),
    .dout   (dout),
    .errf   (errf),
    .ue     (ue)
  );

  always #20 CLK = ~CLK;

  initial begin
    RSTB = 1'b0;
    repeat (8) @(posedge CLK);
    #2 RSTB = 1'b1;
  end

  // ==========================================================================
  // Reference SEC-DED model
  // ==========================================================================
  function automatic logic [3:0] hamming_pos(input int i);
    case (i)
      0: return 4'd3;
      1: return 4'd5;
      2: return 4'd6;
      3: return 4'd7;
      4: return 4'd9;
      5: return 4'd10;
      6: return 4'd11;
      default: return 4'd12;
    endcase
  endfunction

  // Check bit k collects the data bits whose position has bit k set
  function automatic logic [3:0] check_bits(input logic [7:0] d);
    logic [3:0] chk;
    chk = 4'd0;
    for (int i = 0; i < 8; i++) begin
      if (d[i]) chk = chk ^ hamming_pos(i);
    end
    return chk;
  endfunction

  function automatic logic [12:0] encode_byte(input logic [7:0] d, input logic bp);
    logic [3:0] chk;
    chk = check_bits(d);
    if (bp) return {5'd0, d};
    return {^{chk, d}, chk, d};
  endfunction

  // Returns {ue, errf, data}
  function automatic logic [9:0] decode_byte(input logic [12:0] cw, input logic bp);
    logic [7:0] d;
    logic [3:0] syn;
    d   = cw[7:0];
    syn = check_bits(d) ^ cw[11:8];
    if (bp) return {2'b00, d};
    if (^cw) begin
      for (int i = 0; i < 8; i++) begin
        if (hamming_pos(i) == syn) d[i] = ~d[i];
      end
      return {2'b01, d};
    end
    if (syn != 4'd0) return {2'b11, d};
    return {2'b00, d};
  endfunction

  task automatic add_row(input logic [1:0] op, input logic [8:0] addr,
                         input logic [31:0] data, input logic [3:0] bn, input logic bp);
    rows[n_rows].op     = op;
    rows[n_rows].addr   = addr;
    rows[n_rows].data   = data;
    rows[n_rows].ben    = bn;
    rows[n_rows].bypass = bp;
    n_rows++;
  endtask

  task automatic predict_row(input int idx);
    row_t       r;
    logic [9:0] res;
    r = rows[idx];
    for (int b = 0; b < `MRAM_BYTES; b++) begin
      if (r.op == OP_WR && !r.ben[b]) begin
        shadow[r.addr][b] = encode_byte(r.data[b*8 +: 8], r.bypass);
      end else if (r.op == OP_RD) begin
        res = r.ben[b] ? 10'd0 : decode_byte(shadow[r.addr][b], r.bypass);
        held_dout[b*8 +: 8] = res[7:0];
        held_errf[b]        = res[8];
        held_ue[b]          = res[9];
      end
    end
    exp_dout[idx] = held_dout;
    exp_errf[idx] = held_errf;
    exp_ue[idx]   = held_ue;
  endtask

  task automatic drive_row(input int idx);
    a      = rows[idx].addr;
    din    = rows[idx].data;
    ben    = rows[idx].ben;
    bypass = rows[idx].bypass;
    ceb    = (rows[idx].op == OP_IDLE);
    web    = (rows[idx].op != OP_WR);
    predict_row(idx);
  endtask

  task automatic drive_idle();
    ceb    = 1'b1;
    web    = 1'b1;
    ben    = 4'hf;
    bypass = 1'b0;
  endtask

  task automatic check_result(input int idx);
    checks++;
    if (dout !== exp_dout[idx]) begin
      $display("mismatch at %0d ns: row %0d dout %h, expected %h",
               $time, idx, dout, exp_dout[idx]);
      mismatches++;
    end
    if (errf !== exp_errf[idx]) begin
      $display("mismatch at %0d ns: row %0d errf %b, expected %b",
               $time, idx, errf, exp_errf[idx]);
      mismatches++;
    end
    if (ue !== exp_ue[idx]) begin
      $display("mismatch at %0d ns: row %0d ue %b, expected %b",
               $time, idx, ue, exp_ue[idx]);
      mismatches++;
    end
    next_check = idx + 1;
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    logic [31:0] ctl;
    // All eight banks at the same row, full words
    for (int b = 0; b < 8; b++) begin
      add_row(OP_WR, {3'(b), 6'h15}, 32'h1234_5678 ^ (32'(b) * 32'h0101_0101),
              4'h0, 1'b0);
    end
    for (int b = 0; b < 8; b++) begin
      add_row(OP_RD, {3'(b), 6'h15}, 32'h0, 4'h0, 1'b0);
    end
    // Byte masking on write and read
    add_row(OP_WR,   9'h045, 32'haabb_ccdd, 4'h0, 1'b0);
    add_row(OP_WR,   9'h045, 32'h1122_3344, 4'b1010, 1'b0);
    add_row(OP_RD,   9'h045, 32'h0, 4'h0, 1'b0);
    add_row(OP_RD,   9'h045, 32'h0, 4'b0110, 1'b0);
    // Bypass writes plant a single and a double error
    add_row(OP_WR,   9'h1f0, 32'h0000_0001, 4'h0, 1'b1);
    add_row(OP_WR,   9'h0f3, 32'h0000_0300, 4'h0, 1'b1);
    add_row(OP_RD,   9'h1f0, 32'h0, 4'h0, 1'b0);
    add_row(OP_RD,   9'h0f3, 32'h0, 4'h0, 1'b0);
    add_row(OP_RD,   9'h045, 32'h0, 4'h0, 1'b1);
    add_row(OP_RD,   9'h1f0, 32'h0, 4'h0, 1'b1);
    add_row(OP_RD,   9'h0f3, 32'h0, 4'h0, 1'b1);
    // Read right behind a write, then idle cycles hold dout
    add_row(OP_WR,   9'h123, 32'hdead_beef, 4'h0, 1'b0);
    add_row(OP_RD,   9'h123, 32'h0, 4'h0, 1'b0);
    add_row(OP_IDLE, 9'h123, 32'hffff_ffff, 4'h0, 1'b0);
    add_row(OP_IDLE, 9'h000, 32'h0, 4'h0, 1'b1);
    add_row(OP_WR,   9'h123, 32'h0bad_f00d, 4'h0, 1'b0);
    add_row(OP_RD,   9'h123, 32'h0, 4'h0, 1'b0);
    add_row(OP_IDLE, 9'h1ff, 32'h0, 4'hf, 1'b0);
    // Random words, random write bypass, random read mask and bypass
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      ctl = $random(seed);
      add_row(OP_WR, 9'h180 + 9'(i), rnd, 4'h0, ctl[5]);
      add_row(OP_RD, 9'h180 + 9'(i), 32'h0, ctl[3:0], ctl[4]);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    int cnt;
    CLK          = 1'b0;
    a            = '0;
    din          = '0;
    ceb          = 1'b1;
    web          = 1'b1;
    ben          = 4'hf;
    bypass       = 1'b0;
    n_rows       = 0;
    mismatches   = 0;
    other_errors = 0;
    checks       = 0;
    next_check   = 0;
    held_dout    = '0;
    held_errf    = '0;
    held_ue      = '0;
    seed         = 32'hd63ca559;
    build_table();

    cnt = 0;
    while (RSTB !== 1'b1 && cnt < RESET_TIMEOUT) begin
      @(posedge CLK);
      cnt++;
    end
    if (RSTB !== 1'b1) begin
      $display("Reset was never released");
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      for (int i = 0; i < n_rows; i++) begin
        @(posedge CLK);
        #1;
        if (i >= 2) check_result(i - 2);
        #1;
        drive_row(i);
      end

      // Results trail their command by two edges
      cnt = 0;
      while (next_check < n_rows && cnt < DRAIN_TIMEOUT) begin
        @(posedge CLK);
        #1;
        check_result(next_check);
        #1;
        drive_idle();
        cnt++;
      end
      if (next_check < n_rows) begin
        $display("Drain timed out with %0d rows unchecked", n_rows - next_check);
        other_errors++;
      end

      $display("checks %0d, mismatches %0d, other errors %0d",
               checks, mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/mram_pkg.sv
hdl/secded_encoder.sv
hdl/secded_decoder.sv
hdl/mram_bank.sv
hdl/bank_array.sv
hdl/mram_ecc_top.sv
sim/tb_mram_ecc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MRAM ECC testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f \
    --top-module tb_mram_ecc -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_mram_ecc)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF -- '*** TEST PASSED ***'; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
